// File: ooo_backend.f
+incdir+.
ooo_cfg_pkg.sv
ooo_entry_pkg.sv
regstat.sv
rob.sv
alu_pipe.sv
mul_pipe.sv
cdb_arbiter.sv
ooo_backend_top.sv
tb_clkgen.sv
ooo_backend_chk.sv
ooo_backend_tb.sv

// File: ooo_backend_tb.sv
/*
 * Out-of-order back end testbench
 * Random dispatch with flushes, scored against an in-order reference model
 */
`timescale 1ns/1ps

module ooo_backend_tb;

    import ooo_cfg_pkg::*;
    import ooo_entry_pkg::*;

    localparam int NumCycles = 1500;    // Random stimulus phase
    localparam int CommitTmo = 64;      // Max cycles from dispatch to commit

    logic      clk, rst_n, flush_i, disp_valid_i, disp_ready_o;
    unit_sel_t disp_unit_i;
    alu_op_t   disp_op_i;
    xdata_t    disp_a_i, disp_b_i, commit_data_o;
    reg_idx_t  disp_rd_i, disp_rs1_i, disp_rs2_i, commit_rd_o;
    rob_idx_t  disp_rob_idx_o, rs1_rob_idx_o, rs2_rob_idx_o, commit_rob_idx_o;
    logic      rs1_busy_o, rs2_busy_o, commit_valid_o;

    integer   seed = 16112;
    int       err_cnt = 0, chk_cnt, disp_cnt = 0, comm_cnt = 0, cyc = 0, guard;
    logic     timed_out = 1'b0, after_flush = 1'b0;
    // Reference model
    reg_idx_t q_rd[$];                  // In-flight instructions, oldest first
    rob_idx_t q_idx[$];
    xdata_t   q_data[$];
    int       q_cyc[$];                 // Dispatch cycle, for liveness
    int       wr_cnt [REG_NUM];         // Writers in flight per register
    rob_idx_t latest [REG_NUM];         // Youngest producer per register
    int       exp_tail = 0;

    tb_clkgen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    ooo_backend_top u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .flush_i,
        .disp_valid_i, .disp_ready_o, .disp_unit_i, .disp_op_i, .disp_a_i, .disp_b_i,
        .disp_rd_i, .disp_rs1_i, .disp_rs2_i, .disp_rob_idx_o,
        .rs1_busy_o, .rs1_rob_idx_o, .rs2_busy_o, .rs2_rob_idx_o,
        .commit_valid_o, .commit_rd_o, .commit_rob_idx_o, .commit_data_o
    );

    task automatic log_mismatch(input string name, input logic [15:0] exp, input logic [15:0] got);
        err_cnt++;
        $display("FAILED %s exp=%h got=%h", name, exp, got);
    endtask

    task automatic flag_problem(input string what);
        err_cnt++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // Result as the ISA defines it, all modulo 2**16
    function automatic xdata_t expected_result(unit_sel_t unit, alu_op_t op, xdata_t a, xdata_t b);
        logic [31:0] prod;
        prod = {16'b0, a} * {16'b0, b};
        if (unit == UNIT_MUL) return prod[15:0];
        case (op)
            ALU_SUB: return a - b;
            ALU_XOR: return a ^ b;
            default: return a + b;
        endcase
    endfunction

    task automatic clear_model();
        q_rd.delete();
        q_idx.delete();
        q_data.delete();
        q_cyc.delete();
        foreach (wr_cnt[i]) wr_cnt[i] = 0;
        foreach (latest[i]) latest[i] = '0;
        exp_tail = 0;
    endtask

    task automatic drive_stimulus(input logic do_flush, input logic active);
        int unsigned r;
        r = $random(seed);
        disp_valid_i = active && ((r % 10) < 7);    // About 70% of cycles
        r = $random(seed);
        disp_unit_i  = unit_sel_t'(r[0]);
        r = $random(seed);
        disp_op_i    = alu_op_t'(r % 3);
        disp_a_i     = $random(seed);
        disp_b_i     = $random(seed);
        r = $random(seed);
        {disp_rd_i, disp_rs1_i, disp_rs2_i} = r[11:0];
        flush_i      = do_flush;
    endtask

    // ------------------------------
    // Scoring, sampled mid-cycle
    // ------------------------------
    task automatic score_cycle();
        logic fire;
        fire = disp_valid_i && disp_ready_o;
        if (flush_i) begin              // Flush wins over dispatch and commit
            clear_model();
            after_flush = 1'b1;
            return;
        end
        if (after_flush) begin
            assert (!commit_valid_o) else flag_problem("commit right after flush");
            assert (!rs1_busy_o && !rs2_busy_o) else flag_problem("busy register after flush");
            assert (!disp_ready_o) else flag_problem("dispatch ready in the settle cycle");
            after_flush = 1'b0;
        end
        assert (disp_rob_idx_o == rob_idx_t'(exp_tail))
            else log_mismatch("disp_rob_idx_o", exp_tail, disp_rob_idx_o);
        if (q_rd.size() == ROB_DEPTH)
            assert (!disp_ready_o) else flag_problem("dispatch ready with a full ROB");
        if (fire) begin                 // Status reads see the state before this edge
            assert (rs1_busy_o == (wr_cnt[disp_rs1_i] != 0))
                else log_mismatch("rs1_busy_o", wr_cnt[disp_rs1_i] != 0, rs1_busy_o);
            assert (rs1_rob_idx_o == latest[disp_rs1_i])
                else log_mismatch("rs1_rob_idx_o", latest[disp_rs1_i], rs1_rob_idx_o);
            assert (rs2_busy_o == (wr_cnt[disp_rs2_i] != 0))
                else log_mismatch("rs2_busy_o", wr_cnt[disp_rs2_i] != 0, rs2_busy_o);
            assert (rs2_rob_idx_o == latest[disp_rs2_i])
                else log_mismatch("rs2_rob_idx_o", latest[disp_rs2_i], rs2_rob_idx_o);
        end
        if (commit_valid_o) begin
            if (q_rd.size() == 0) begin
                flag_problem("commit with no instruction in flight");
            end else begin          // Oldest first, so order is checked too
                assert (commit_rd_o == q_rd[0]) else log_mismatch("commit_rd_o", q_rd[0], commit_rd_o);
                assert (commit_rob_idx_o == q_idx[0])
                    else log_mismatch("commit_rob_idx_o", q_idx[0], commit_rob_idx_o);
                assert (commit_data_o == q_data[0])
                    else log_mismatch("commit_data_o", q_data[0], commit_data_o);
                wr_cnt[q_rd[0]]--;
                void'(q_rd.pop_front());
                void'(q_idx.pop_front());
                void'(q_data.pop_front());
                void'(q_cyc.pop_front());
                comm_cnt++;
            end
        end
        if (fire) begin
            q_rd.push_back(disp_rd_i);
            q_idx.push_back(rob_idx_t'(exp_tail));
            q_data.push_back(expected_result(disp_unit_i, disp_op_i, disp_a_i, disp_b_i));
            q_cyc.push_back(cyc);
            wr_cnt[disp_rd_i]++;
            latest[disp_rd_i] = rob_idx_t'(exp_tail);
            exp_tail = (exp_tail + 1) % ROB_DEPTH;
            disp_cnt++;
        end
        if (q_cyc.size() != 0 && (cyc - q_cyc[0]) > CommitTmo) begin
            flag_problem($sformatf("ROB entry %0d did not commit in time", q_idx[0]));
            timed_out = 1'b1;
        end
    endtask

    initial begin
        flush_i      = 1'b0;
        disp_valid_i = 1'b0;
        disp_unit_i  = UNIT_ALU;
        disp_op_i    = ALU_ADD;
        {disp_a_i, disp_b_i} = '0;
        {disp_rd_i, disp_rs1_i, disp_rs2_i} = '0;
        clear_model();

        guard = 0;
        while (rst_n !== 1'b1 && guard < 40) begin
            @(posedge clk);
            guard++;
        end
        if (rst_n !== 1'b1) begin
            flag_problem("reset never released");
            timed_out = 1'b1;
        end

        // Random phase, one fixed flush plus rare random ones
        while (cyc < NumCycles && !timed_out) begin
            @(posedge clk);
            #2 drive_stimulus((cyc == 400) || (({$random(seed)} % 256) == 0), 1'b1);
            @(negedge clk);
            score_cycle();
            cyc++;
        end

        // Drain what is still in flight
        guard = 0;
        while (q_rd.size() != 0 && !timed_out && guard < 2 * CommitTmo) begin
            @(posedge clk);
            #2 drive_stimulus(1'b0, 1'b0);
            @(negedge clk);
            score_cycle();
            cyc++;
            guard++;
        end
        if (q_rd.size() != 0 && !timed_out) flag_problem("ROB did not drain");

        chk_cnt = u_dut.u_arb.u_chk.fail_cnt + u_dut.u_rob.u_chk.fail_cnt;
        $display("dispatched=%0d committed=%0d check errors=%0d assertion errors=%0d",
                 disp_cnt, comm_cnt, err_cnt, chk_cnt);
        if (err_cnt == 0 && chk_cnt == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: ooo_backend_chk.sv
/*
 * Back end protocol checker
 * Bound into the CDB arbiter and the ROB
 */
`timescale 1ns/1ps

module ooo_backend_chk #(
    parameter bit ChkBus = 1'b1     // 1 for the arbiter side, 0 for the ROB side
) (
    input logic clk_i,
    input logic rst_n_i,
    input logic flush_i,
    input logic alu_req_i,
    input logic mul_req_i,
    input logic alu_grant_i,
    input logic mul_grant_i,
    input logic commit_valid_i
);

    int fail_cnt = 0;   // Assertion failures seen by this instance

    if (ChkBus) begin : g_bus
        // ------------------------------
        // Result bus ownership
        // ------------------------------
        a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            !(alu_grant_i && mul_grant_i))
            else begin
                fail_cnt++;
                $error("both pipes granted the result bus in one cycle");
            end

        a_alu_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            alu_grant_i |-> alu_req_i)
            else begin
                fail_cnt++;
                $error("ALU granted without a request");
            end

        a_mul_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            mul_grant_i |-> mul_req_i)
            else begin
                fail_cnt++;
                $error("MUL granted without a request");
            end
    end else begin : g_commit
        // ROB is empty right after a flush
        a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            flush_i |=> !commit_valid_i)
            else begin
                fail_cnt++;
                $error("commit in the cycle after a flush");
            end
    end

endmodule

bind cdb_arbiter ooo_backend_chk #(.ChkBus(1'b1)) u_chk (
    .clk_i, .rst_n_i, .flush_i,
    .alu_req_i, .mul_req_i,
    .alu_grant_i(alu_grant_o), .mul_grant_i(mul_grant_o),
    .commit_valid_i(1'b0)
);

bind rob ooo_backend_chk #(.ChkBus(1'b0)) u_chk (
    .clk_i, .rst_n_i, .flush_i,
    .alu_req_i(1'b0), .mul_req_i(1'b0), .alu_grant_i(1'b0), .mul_grant_i(1'b0),
    .commit_valid_i(commit_valid_o)
);

// File: tb_clkgen.sv
/*
 * Testbench clock and reset
 * 40 ns clock, active-low reset held for the first 16 cycles
 */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;     // 40 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        #1 rst_n_o = 1'b1;              // Release just after an edge
    end

endmodule

// File: ooo_backend_top.sv
/*
 * Out-of-order back end top level
 * Dispatch, status table, ROB, two execution pipes and the CDB arbiter
 */
`timescale 1ns/1ps

module ooo_backend_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    // Dispatch
    input  logic                      disp_valid_i,
    output logic                      disp_ready_o,
    input  ooo_entry_pkg::unit_sel_t  disp_unit_i,
    input  ooo_entry_pkg::alu_op_t    disp_op_i,
    input  ooo_cfg_pkg::xdata_t       disp_a_i,
    input  ooo_cfg_pkg::xdata_t       disp_b_i,
    input  ooo_cfg_pkg::reg_idx_t     disp_rd_i,
    input  ooo_cfg_pkg::reg_idx_t     disp_rs1_i,
    input  ooo_cfg_pkg::reg_idx_t     disp_rs2_i,
    output ooo_cfg_pkg::rob_idx_t     disp_rob_idx_o,
    // Operand status
    output logic                      rs1_busy_o,
    output ooo_cfg_pkg::rob_idx_t     rs1_rob_idx_o,
    output logic                      rs2_busy_o,
    output ooo_cfg_pkg::rob_idx_t     rs2_rob_idx_o,
    // Commit
    output logic                      commit_valid_o,
    output ooo_cfg_pkg::reg_idx_t     commit_rd_o,
    output ooo_cfg_pkg::rob_idx_t     commit_rob_idx_o,
    output ooo_cfg_pkg::xdata_t       commit_data_o
);

    import ooo_cfg_pkg::*;
    import ooo_entry_pkg::*;

    logic     rob_full, disp_fire;
    logic     alu_in_valid, alu_in_ready, mul_in_valid, mul_in_ready;
    logic     alu_res_valid, mul_res_valid, alu_grant, mul_grant, cdb_valid;
    rob_idx_t alu_res_idx, mul_res_idx, cdb_rob_idx;
    xdata_t   alu_res_data, mul_res_data, cdb_data;

    // ------------------------------
    // Dispatch handshake
    // ------------------------------
    assign disp_ready_o = !rob_full && (disp_unit_i == UNIT_ALU ? alu_in_ready : mul_in_ready);
    assign disp_fire    = disp_valid_i && disp_ready_o;
    assign alu_in_valid = disp_fire && (disp_unit_i == UNIT_ALU);
    assign mul_in_valid = disp_fire && (disp_unit_i == UNIT_MUL);

    regstat u_regstat (
        .clk_i, .rst_n_i, .flush_i,
        .disp_we_i(disp_fire), .disp_rd_i, .disp_rob_idx_i(disp_rob_idx_o),
        .rs1_idx_i(disp_rs1_i), .rs2_idx_i(disp_rs2_i),
        .rs1_busy_o, .rs1_rob_idx_o, .rs2_busy_o, .rs2_rob_idx_o,
        .comm_we_i(commit_valid_o), .comm_rd_i(commit_rd_o)
    );

    rob u_rob (
        .clk_i, .rst_n_i, .flush_i,
        .alloc_i(disp_fire), .alloc_rd_i(disp_rd_i), .full_o(rob_full), .tail_o(disp_rob_idx_o),
        .cdb_valid_i(cdb_valid), .cdb_rob_idx_i(cdb_rob_idx), .cdb_data_i(cdb_data),
        .commit_valid_o, .commit_rd_o, .commit_rob_idx_o, .commit_data_o
    );

    // ------------------------------
    // Execution pipes and result bus
    // ------------------------------
    alu_pipe u_alu (
        .clk_i, .rst_n_i, .flush_i,
        .in_valid_i(alu_in_valid), .in_ready_o(alu_in_ready), .op_i(disp_op_i),
        .a_i(disp_a_i), .b_i(disp_b_i), .rob_idx_i(disp_rob_idx_o),
        .res_valid_o(alu_res_valid), .res_rob_idx_o(alu_res_idx), .res_data_o(alu_res_data),
        .grant_i(alu_grant)
    );

    mul_pipe u_mul (
        .clk_i, .rst_n_i, .flush_i,
        .in_valid_i(mul_in_valid), .in_ready_o(mul_in_ready),
        .a_i(disp_a_i), .b_i(disp_b_i), .rob_idx_i(disp_rob_idx_o),
        .res_valid_o(mul_res_valid), .res_rob_idx_o(mul_res_idx), .res_data_o(mul_res_data),
        .grant_i(mul_grant)
    );

    cdb_arbiter u_arb (
        .clk_i, .rst_n_i, .flush_i,
        .alu_req_i(alu_res_valid), .mul_req_i(mul_res_valid),
        .alu_rob_idx_i(alu_res_idx), .mul_rob_idx_i(mul_res_idx),
        .alu_data_i(alu_res_data), .mul_data_i(mul_res_data),
        .alu_grant_o(alu_grant), .mul_grant_o(mul_grant),
        .cdb_valid_o(cdb_valid), .cdb_rob_idx_o(cdb_rob_idx), .cdb_data_o(cdb_data)
    );

endmodule

// File: cdb_arbiter.sv
/*
 * CDB arbiter
 * Round-robin between ALU and MUL for the shared result bus
 */
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   alu_req_i,
    input  logic                   mul_req_i,
    input  ooo_cfg_pkg::rob_idx_t  alu_rob_idx_i,
    input  ooo_cfg_pkg::rob_idx_t  mul_rob_idx_i,
    input  ooo_cfg_pkg::xdata_t    alu_data_i,
    input  ooo_cfg_pkg::xdata_t    mul_data_i,
    output logic                   alu_grant_o,
    output logic                   mul_grant_o,
    output logic                   cdb_valid_o,
    output ooo_cfg_pkg::rob_idx_t  cdb_rob_idx_o,
    output ooo_cfg_pkg::xdata_t    cdb_data_o
);

    import ooo_entry_pkg::*;

    logic last_mul_q;       // Last winner, 1 for MUL
    cdb_t cdb;

    // On contention the pipe that lost last time wins
    assign alu_grant_o = alu_req_i && (!mul_req_i || last_mul_q);
    assign mul_grant_o = mul_req_i && (!alu_req_i || !last_mul_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_mul_q <= 1'b0;
        end else if (flush_i) begin
            last_mul_q <= 1'b0;
        end else if (alu_grant_o || mul_grant_o) begin
            last_mul_q <= mul_grant_o;
        end
    end

    // Bus mux from the winner
    always_comb begin
        cdb.valid   = alu_grant_o || mul_grant_o;
        cdb.rob_idx = mul_grant_o ? mul_rob_idx_i : alu_rob_idx_i;
        cdb.data    = mul_grant_o ? mul_data_i    : alu_data_i;
    end

    assign cdb_valid_o   = cdb.valid;
    assign cdb_rob_idx_o = cdb.rob_idx;
    assign cdb_data_o    = cdb.data;

endmodule

// File: mul_pipe.sv
/*
 * Multiplier pipe
 * Three stages, low half of a*b; the whole pipe stalls on back-pressure
 */
`timescale 1ns/1ps

module mul_pipe (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  ooo_cfg_pkg::xdata_t    a_i,
    input  ooo_cfg_pkg::xdata_t    b_i,
    input  ooo_cfg_pkg::rob_idx_t  rob_idx_i,
    output logic                   res_valid_o,
    output ooo_cfg_pkg::rob_idx_t  res_rob_idx_o,
    output ooo_cfg_pkg::xdata_t    res_data_o,
    input  logic                   grant_i
);

    import ooo_cfg_pkg::*;

    localparam int Half = XLEN / 2;

    logic [2:0]      vld_q;             // Stage valids, bit 0 is stage 1
    rob_idx_t        idx_q [3];
    xdata_t          s1_lo_q;           // a * b[7:0]
    logic [Half-1:0] s1_hi_q;           // a[7:0] * b[15:8], only the low half survives
    xdata_t          s2_q;              // Summed product
    xdata_t          s3_q;              // Result waiting for the bus
    logic            adv;

    assign adv        = !vld_q[2] || grant_i;   // Stage 3 empty or leaving
    assign in_ready_o = adv;

    // ------------------------------
    // Stage valids
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else if (flush_i) begin
            vld_q <= '0;
        end else if (adv) begin
            vld_q <= {vld_q[1:0], in_valid_i};
        end
    end

    // ------------------------------
    // Data path
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (adv) begin
            s1_lo_q  <= a_i * xdata_t'(b_i[Half-1:0]);   // Partial products
            s1_hi_q  <= a_i[Half-1:0] * b_i[XLEN-1:Half];
            s2_q     <= s1_lo_q + {s1_hi_q, {Half{1'b0}}};
            s3_q     <= s2_q;
            idx_q[0] <= rob_idx_i;
            idx_q[1] <= idx_q[0];
            idx_q[2] <= idx_q[1];
        end
    end

    assign res_valid_o   = vld_q[2];
    assign res_rob_idx_o = idx_q[2];
    assign res_data_o    = s3_q;

endmodule

// File: alu_pipe.sv
/*
 * ALU pipe
 * Single-stage add/sub/xor with one result slot held until granted
 */
`timescale 1ns/1ps

module alu_pipe (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  ooo_entry_pkg::alu_op_t    op_i,
    input  ooo_cfg_pkg::xdata_t       a_i,
    input  ooo_cfg_pkg::xdata_t       b_i,
    input  ooo_cfg_pkg::rob_idx_t     rob_idx_i,
    output logic                      res_valid_o,
    output ooo_cfg_pkg::rob_idx_t     res_rob_idx_o,
    output ooo_cfg_pkg::xdata_t       res_data_o,
    input  logic                      grant_i
);

    import ooo_cfg_pkg::*;
    import ooo_entry_pkg::*;

    logic     valid_q;      // Slot occupied
    rob_idx_t rob_idx_q;
    xdata_t   data_q;
    xdata_t   result;

    always_comb begin
        case (op_i)
            ALU_SUB: result = a_i - b_i;
            ALU_XOR: result = a_i ^ b_i;
            default: result = a_i + b_i;    // Wraps modulo 2**16
        endcase
    end

    assign in_ready_o = !valid_q || grant_i;    // Slot frees on grant

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            valid_q <= 1'b1;
        end else if (grant_i) begin
            valid_q <= 1'b0;
        end
    end

    // Payload, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            rob_idx_q <= rob_idx_i;
            data_q    <= result;
        end
    end

    assign res_valid_o   = valid_q;
    assign res_rob_idx_o = rob_idx_q;
    assign res_data_o    = data_q;

endmodule

// File: rob.sv
/*
 * Reorder buffer
 * Circular buffer: tail allocation, CDB write-back and in-order commit
 */
`timescale 1ns/1ps
`include "ooo_backend_macros.svh"

module rob (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // Allocation at dispatch
    input  logic                   alloc_i,
    input  ooo_cfg_pkg::reg_idx_t  alloc_rd_i,
    output logic                   full_o,
    output ooo_cfg_pkg::rob_idx_t  tail_o,
    // Write-back from the CDB
    input  logic                   cdb_valid_i,
    input  ooo_cfg_pkg::rob_idx_t  cdb_rob_idx_i,
    input  ooo_cfg_pkg::xdata_t    cdb_data_i,
    // Commit
    output logic                   commit_valid_o,
    output ooo_cfg_pkg::reg_idx_t  commit_rd_o,
    output ooo_cfg_pkg::rob_idx_t  commit_rob_idx_o,
    output ooo_cfg_pkg::xdata_t    commit_data_o
);

    import ooo_cfg_pkg::*;
    import ooo_entry_pkg::*;

    localparam int CntW = $clog2(`OOO_ROB_DEPTH) + 1;   // Counts 0 to depth

    rob_entry_t      mem [`OOO_ROB_DEPTH];
    rob_idx_t        head_q;            // Oldest entry
    rob_idx_t        tail_q;            // Next free entry
    logic [CntW-1:0] count_q;           // Occupied entries
    logic            settle_q;          // Low for one cycle after reset or flush
    logic            retire;

    // ------------------------------
    // Commit side
    // ------------------------------
    assign retire           = (count_q != '0) && mem[head_q].done;
    assign commit_valid_o   = retire;
    assign commit_rd_o      = mem[head_q].rd;
    assign commit_rob_idx_o = head_q;
    assign commit_data_o    = mem[head_q].data;

    // Full also while settling, which blocks dispatch for that cycle
    assign full_o = (count_q == CntW'(`OOO_ROB_DEPTH)) || !settle_q;
    assign tail_o = tail_q;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            settle_q <= 1'b0;
        end else if (flush_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            settle_q <= 1'b0;
        end else begin
            settle_q <= 1'b1;
            if (alloc_i) tail_q <= tail_q + 1'b1;    // Wraps, depth is a power of 2
            if (retire)  head_q <= head_q + 1'b1;
            count_q <= count_q + CntW'(alloc_i) - CntW'(retire);
        end
    end

    // ------------------------------
    // Entry storage
    // ------------------------------
    // A live entry is never allocated, so the two writes never meet
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            mem[tail_q].done <= 1'b0;
            mem[tail_q].rd   <= alloc_rd_i;
        end
        if (cdb_valid_i) begin
            mem[cdb_rob_idx_i].done <= 1'b1;
            mem[cdb_rob_idx_i].data <= cdb_data_i;
        end
    end

endmodule

// File: regstat.sv
/*
 * Register status table
 * Per register in-flight writer count and youngest producer ROB index
 */
`timescale 1ns/1ps

module regstat (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // Dispatch write port
    input  logic                   disp_we_i,
    input  ooo_cfg_pkg::reg_idx_t  disp_rd_i,
    input  ooo_cfg_pkg::rob_idx_t  disp_rob_idx_i,
    // Operand read ports
    input  ooo_cfg_pkg::reg_idx_t  rs1_idx_i,
    input  ooo_cfg_pkg::reg_idx_t  rs2_idx_i,
    output logic                   rs1_busy_o,
    output ooo_cfg_pkg::rob_idx_t  rs1_rob_idx_o,
    output logic                   rs2_busy_o,
    output ooo_cfg_pkg::rob_idx_t  rs2_rob_idx_o,
    // Commit write port
    input  logic                   comm_we_i,
    input  ooo_cfg_pkg::reg_idx_t  comm_rd_i
);

    import ooo_cfg_pkg::*;
    import ooo_entry_pkg::*;

    regstat_entry_t     tbl [REG_NUM];      // Status of each register
    logic [REG_NUM-1:0] disp_hit;           // One-hot dispatch target
    logic [REG_NUM-1:0] comm_hit;           // One-hot commit target

    // ------------------------------
    // Write port decode
    // ------------------------------
    always_comb begin
        disp_hit = '0;
        comm_hit = '0;
        if (disp_we_i) disp_hit[disp_rd_i] = 1'b1;
        if (comm_we_i) comm_hit[comm_rd_i] = 1'b1;
    end

    // ------------------------------
    // Table update
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            foreach (tbl[i]) tbl[i] <= '0;
        end else if (flush_i) begin
            foreach (tbl[i]) tbl[i] <= '0;      // Nothing left in flight
        end else begin
            for (int i = 0; i < REG_NUM; i++) begin
                // Dispatch and commit to one register cancel out
                if (disp_hit[i] && !comm_hit[i]) begin
                    tbl[i].busy <= tbl[i].busy + 1'b1;
                end else if (comm_hit[i] && !disp_hit[i]) begin
                    tbl[i].busy <= tbl[i].busy - 1'b1;
                end
                if (disp_hit[i]) tbl[i].rob_idx <= disp_rob_idx_i;  // Youngest writer wins
            end
        end
    end

    // ------------------------------
    // Read ports, state before update
    // ------------------------------
    assign rs1_busy_o    = |tbl[rs1_idx_i].busy;
    assign rs1_rob_idx_o = tbl[rs1_idx_i].rob_idx;
    assign rs2_busy_o    = |tbl[rs2_idx_i].busy;
    assign rs2_rob_idx_o = tbl[rs2_idx_i].rob_idx;

endmodule

// File: ooo_entry_pkg.sv
/*
 * Back end record package
 * Operation codes and the entries held in status table, ROB and CDB
 */
package ooo_entry_pkg;

    import ooo_cfg_pkg::*;

    // ------------------------------
    // Operation codes
    // ------------------------------
    typedef enum logic {
        UNIT_ALU = 1'b0,        // Single-stage add/sub/xor
        UNIT_MUL = 1'b1         // Three-stage multiplier
    } unit_sel_t;

    // ALU function, ignored by the multiplier
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_XOR = 2'd2
    } alu_op_t;

    // ------------------------------
    // Records
    // ------------------------------
    // Register status: pending writers and the latest producer
    typedef struct packed {
        busy_cnt_t busy;        // Nonzero while a writer is in flight
        rob_idx_t  rob_idx;     // ROB entry of the youngest writer
    } regstat_entry_t;

    typedef struct packed {
        logic     done;         // Result has been written back
        reg_idx_t rd;           // Destination register
        xdata_t   data;         // Result value
    } rob_entry_t;

    // Common data bus beat
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        xdata_t   data;
    } cdb_t;

endpackage

// File: ooo_cfg_pkg.sv
/*
 * Back end configuration package
 * Sizes and index/width types derived from the configuration macros
 */
`include "ooo_backend_macros.svh"

package ooo_cfg_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int REG_NUM   = `OOO_REG_NUM;
    localparam int ROB_DEPTH = `OOO_ROB_DEPTH;
    localparam int REG_IDX_W = $clog2(REG_NUM);     // 4 bits
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);   // 3 bits
    localparam int XLEN      = `OOO_XLEN;
    localparam int BUSY_W    = `OOO_BUSY_W;

    // ------------------------------
    // Types
    // ------------------------------
    // Register file index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Reorder buffer entry index
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef logic [XLEN-1:0]      xdata_t;      // Operand and result word
    typedef logic [BUSY_W-1:0]    busy_cnt_t;   // Count of in-flight writers

endpackage

// File: ooo_backend_macros.svh
/*
 * Out-of-order back end configuration
 * Sizes of the register space, the reorder buffer and the data path
 */
`ifndef OOO_BACKEND_MACROS_SVH
`define OOO_BACKEND_MACROS_SVH

// ------------------------------
// Register space
// ------------------------------
`define OOO_REG_NUM     16  // Architectural registers

// ------------------------------
// Reorder buffer
// ------------------------------
`define OOO_ROB_DEPTH   8   // Entries, power of 2

// ------------------------------
// Data path
// ------------------------------
`define OOO_XLEN        16  // Data word width
`define OOO_BUSY_W      4   // In-flight writer counter, holds ROB depth plus one

`endif
